// File: Bender.yml
package:
  name: valu

sources:
  - files:
      - logic/valu_pkg.sv
      - logic/valu_apb_regs.sv
      - logic/valu_dispatch.sv
      - logic/valu_lane.sv
      - logic/valu_collect.sv
      - logic/valu_top.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/valu_tb.sv

// File: bench/valu_tb_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference model of the vector ALU, one call per command
// Works element by element from the register-level rules
// Signed ordering uses two's complement at the element width
////////////////////////////////////////////////////////////////////////////

`ifndef VALU_TB_MODEL_SVH
`define VALU_TB_MODEL_SVH

// Element value read as a signed number of width ew
function automatic longint to_signed(input logic [31:0] v, input int ew);
    if (v[ew-1]) begin
        return longint'(v) - (longint'(1) << ew);
    end
    return longint'(v);
endfunction

function automatic void model_op(input logic [3:0] op, input logic [1:0] sew,
                                 input logic [4:0] vl, input logic [127:0] a,
                                 input logic [127:0] b, output logic [127:0] res,
                                 output logic [15:0] mask);
    int          ew;
    int          n;
    logic [31:0] emask;
    logic [31:0] ea;
    logic [31:0] eb;
    logic [31:0] r;
    logic [31:0] sum;
    longint      sa;
    longint      sb;
    ew    = 8 << sew;
    n     = (int'(vl) > 128 / ew) ? 128 / ew : int'(vl);
    emask = (ew == 32) ? 32'hffff_ffff : ((32'h1 << ew) - 1);
    res   = '0;
    mask  = '0;
    sum   = b[31:0] & emask;
    for (int i = 0; i < n; i++) begin
        ea = 32'(a >> (i * ew)) & emask;
        eb = 32'(b >> (i * ew)) & emask;
        sa = to_signed(ea, ew);
        sb = to_signed(eb, ew);
        r  = '0;
        case (op)
            ADD:    r = ea + eb;
            SUB:    r = ea - eb;
            AND:    r = ea & eb;
            OR:     r = ea | eb;
            XOR:    r = ea ^ eb;
            MIN:    r = (sa < sb) ? ea : eb;
            MAX:    r = (sa > sb) ? ea : eb;
            MINU:   r = (ea < eb) ? ea : eb;
            MAXU:   r = (ea > eb) ? ea : eb;
            MSEQ:   mask[i] = (ea == eb);
            MSLT:   mask[i] = (sa < sb);
            MSLTU:  mask[i] = (ea < eb);
            REDSUM: sum = sum + ea;
            default: r = '0;
        endcase
        res = res | (128'(r & emask) << (i * ew));
    end
    // Reduction result only in word 0
    if (op == REDSUM) begin
        res = 128'(sum & emask);
    end
endfunction

`endif

// File: bench/valu_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the vector ALU over APB, random stimulus from an LFSR
// Bus is driven on falling edges, outputs sampled 1 ns later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_tb;
    import valu_pkg::*;

    `include "valu_tb_model.svh"

    // Up to 20 two-cycle transfers per operation, plus reset
    localparam int OPS        = 300;
    localparam int CYC_PER_OP = 40;
    localparam int LIMIT      = OPS * CYC_PER_OP + 16;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_q = 32'd81;
    int          errors;
    int          checks;
    int          tests;

    valu_top dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic random_vec(output logic [127:0] v);
        for (int w = 0; w < 4; w++) begin
            v[w*32 +: 32] = rand_bits(32);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        compare_word("pready", 32'd1, 32'(pready));
        @(posedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        compare_word($sformatf("pslverr@%h", addr), 32'd0, 32'(err));
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        compare_word($sformatf("pslverr@%h", addr), 32'd0, 32'(err));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operation helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic start_op(input logic [3:0] op, input logic [1:0] sew, input logic [4:0] vl,
                            input logic [127:0] a, input logic [127:0] b);
        for (int w = 0; w < 4; w++) begin
            reg_write(REG_OPA + 8'(4 * w), a[w*32 +: 32]);
            reg_write(REG_OPB + 8'(4 * w), b[w*32 +: 32]);
        end
        reg_write(REG_VL, 32'(vl));
        // Go in bit 8
        reg_write(REG_CMD, {23'h0, 1'b1, 2'b00, sew, op});
    endtask

    task automatic wait_done();
        logic [31:0] st;
        do begin
            reg_read(REG_STATUS, st);
            // Busy and done flip on the same edge
            compare_word("STATUS.busy", 32'(!st[1]), 32'(st[0]));
        end while (!st[1]);
    endtask

    task automatic check_outputs(input logic [3:0] op, input logic [1:0] sew,
                                 input logic [4:0] vl, input logic [127:0] a,
                                 input logic [127:0] b);
        logic [127:0] exp_res;
        logic [15:0]  exp_mask;
        logic [31:0]  rd;
        model_op(op, sew, vl, a, b, exp_res, exp_mask);
        for (int w = 0; w < 4; w++) begin
            reg_read(REG_RES + 8'(4 * w), rd);
            compare_word($sformatf("RES[%0d] op=%0d sew=%0d vl=%0d", w, op, sew, vl),
                         exp_res[w*32 +: 32], rd);
        end
        reg_read(REG_MASK, rd);
        compare_word($sformatf("MASK op=%0d sew=%0d vl=%0d", op, sew, vl), 32'(exp_mask), rd);
    endtask

    // kind 0 logic and arithmetic, 1 min and max, 2 compares, 3 reduction
    task automatic run_random(input int n, input int kind, input string label);
        logic [127:0] a;
        logic [127:0] b;
        logic [3:0]   op;
        logic [1:0]   sew;
        logic [4:0]   vl;
        int           err0;
        err0 = errors;
        for (int i = 0; i < n; i++) begin
            case (kind)
                0:       op = 4'(rand_bits(3) % 5);
                1:       op = 4'(MIN) + 4'(rand_bits(2));
                2:       op = 4'(MSEQ) + 4'(rand_bits(2) % 3);
                default: op = 4'(REDSUM);
            endcase
            sew = 2'(rand_bits(2) % 3);
            vl  = 5'(rand_bits(5));
            random_vec(a);
            random_vec(b);
            start_op(op, sew, vl, a, b);
            wait_done();
            check_outputs(op, sew, vl, a, b);
        end
        bus_idle();
        tests++;
        $display("test %0d %s: %0d ops, %0d errors", tests, label, n, errors - err0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_values();
        logic [31:0] rd;
        int          err0;
        err0 = errors;
        reg_read(REG_STATUS, rd);
        compare_word("STATUS", 32'h0, rd);
        for (int w = 0; w < 4; w++) begin
            reg_read(REG_RES + 8'(4 * w), rd);
            compare_word($sformatf("RES[%0d]", w), 32'h0, rd);
        end
        reg_read(REG_MASK, rd);
        compare_word("MASK", 32'h0, rd);
        bus_idle();
        tests++;
        $display("test %0d reset values: %0d errors", tests, errors - err0);
    endtask

    task automatic bus_errors();
        logic [127:0] a;
        logic [127:0] b;
        logic [31:0]  rd;
        logic         err;
        int           err0;
        err0 = errors;
        apb_xfer(1'b0, 8'h50, 32'h0, rd, err);
        compare_word("pslverr@50", 32'd1, 32'(err));
        apb_xfer(1'b0, 8'h0c, 32'h0, rd, err);
        compare_word("pslverr@0c", 32'd1, 32'(err));

        // Operand write straight after go lands while busy
        random_vec(a);
        random_vec(b);
        start_op(4'(REDSUM), 2'(EW8), 5'd16, a, b);
        apb_xfer(1'b1, REG_OPA, ~a[31:0], rd, err);
        compare_word("pslverr OPA busy", 32'd1, 32'(err));
        wait_done();
        reg_read(REG_OPA, rd);
        compare_word("OPA[0]", a[31:0], rd);
        check_outputs(4'(REDSUM), 2'(EW8), 5'd16, a, b);

        // Command write while busy, op and sew must stay
        start_op(4'(REDSUM), 2'(EW16), 5'd5, a, b);
        apb_xfer(1'b1, REG_CMD, {23'h0, 1'b1, 2'b00, 2'(EW32), 4'(ADD)}, rd, err);
        compare_word("pslverr CMD busy", 32'd1, 32'(err));
        wait_done();
        reg_read(REG_CMD, rd);
        compare_word("CMD", {26'h0, 2'(EW16), 4'(REDSUM)}, rd);
        check_outputs(4'(REDSUM), 2'(EW16), 5'd5, a, b);
        bus_idle();
        tests++;
        $display("test %0d bus errors: %0d errors", tests, errors - err0);
    endtask

    initial begin
        clk     = 1'b0;
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        reset_values();
        run_random(80, 0, "add sub and or xor");
        run_random(60, 1, "min max minu maxu");
        run_random(60, 2, "compare mask");
        run_random(60, 3, "redsum");
        bus_errors();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: logic/valu_apb_regs.sv
////////////////////////////////////////////////////////////////////////////
// APB register block, no wait states
// CMD, VL, OPA and OPB writes while busy are refused with pslverr
// Result and mask are captured on done and stay readable at all times
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_apb_regs (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [valu_pkg::APB_AW-1:0] paddr_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  logic                        busy_i,
    input  logic                        done_i,
    input  logic [valu_pkg::VLEN-1:0]   result_i,
    input  logic [15:0]                 mask_i,
    output logic                        start_o,
    output valu_pkg::valu_op_e          op_o,
    output valu_pkg::sew_e              sew_o,
    output logic [4:0]                  vl_o,
    output logic [valu_pkg::VLEN-1:0]   opa_o,
    output logic [valu_pkg::VLEN-1:0]   opb_o
);
    import valu_pkg::*;

    logic                        access;
    logic                        aligned;
    logic [1:0]                  widx;
    logic                        is_cmd;
    logic                        is_vl;
    logic                        is_status;
    logic                        is_opa;
    logic                        is_opb;
    logic                        is_res;
    logic                        is_mask;
    logic                        cfg_hit;
    logic                        mapped;
    logic                        wr_ok;
    logic                        cmd_wr;

    valu_op_e                    op_q;
    sew_e                        sew_q;
    logic [4:0]                  vl_q;
    logic                        done_q;
    logic [LANES-1:0][LLEN-1:0]  opa_q;
    logic [LANES-1:0][LLEN-1:0]  opb_q;
    logic [LANES-1:0][LLEN-1:0]  res_q;
    logic [15:0]                 mask_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    assign access    = psel_i && penable_i;
    assign aligned   = (paddr_i[1:0] == 2'b00);
    assign widx      = paddr_i[3:2];

    assign is_cmd    = (paddr_i == REG_CMD);
    assign is_vl     = (paddr_i == REG_VL);
    assign is_status = (paddr_i == REG_STATUS);
    assign is_opa    = aligned && (paddr_i[7:4] == REG_OPA[7:4]);
    assign is_opb    = aligned && (paddr_i[7:4] == REG_OPB[7:4]);
    assign is_res    = aligned && (paddr_i[7:4] == REG_RES[7:4]);
    assign is_mask   = (paddr_i == REG_MASK);

    assign cfg_hit   = is_cmd || is_vl || is_opa || is_opb;
    assign mapped    = cfg_hit || is_status || is_res || is_mask;

    assign pready_o  = access;
    assign pslverr_o = access && (!mapped || (pwrite_i && busy_i && cfg_hit));
    assign wr_ok     = access && pwrite_i && !pslverr_o;
    assign cmd_wr    = wr_ok && is_cmd;

    // Start fires in the access phase, so the dispatcher sees the new op and sew
    assign start_o   = cmd_wr && pwdata_i[8];
    assign op_o      = cmd_wr ? valu_op_e'(pwdata_i[3:0]) : op_q;
    assign sew_o     = cmd_wr ? sew_e'(pwdata_i[5:4]) : sew_q;
    assign vl_o      = vl_q;
    assign opa_o     = opa_q;
    assign opb_o     = opb_q;

    ////////////////////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q   <= ADD;
            sew_q  <= EW8;
            vl_q   <= '0;
            done_q <= 1'b0;
            res_q  <= '0;
            mask_q <= '0;
        end else begin
            if (cmd_wr) begin
                op_q   <= valu_op_e'(pwdata_i[3:0]);
                sew_q  <= sew_e'(pwdata_i[5:4]);
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
            if (wr_ok && is_vl) begin
                vl_q <= pwdata_i[4:0];
            end
            if (done_i) begin
                res_q  <= result_i;
                mask_q <= mask_i;
            end
        end
    end

    // Operand words
    always_ff @(posedge clk) begin
        if (wr_ok && is_opa) begin
            opa_q[widx] <= pwdata_i;
        end
        if (wr_ok && is_opb) begin
            opb_q[widx] <= pwdata_i;
        end
    end

    // Read data
    always_comb begin
        prdata_o = '0;
        if (is_cmd)    prdata_o = {26'h0, sew_q, op_q};
        if (is_vl)     prdata_o = {27'h0, vl_q};
        if (is_status) prdata_o = {30'h0, done_q, busy_i};
        if (is_opa)    prdata_o = opa_q[widx];
        if (is_opb)    prdata_o = opb_q[widx];
        if (is_res)    prdata_o = res_q[widx];
        if (is_mask)   prdata_o = {16'h0, mask_q};
    end

    // Error only in an access phase that followed its setup phase
    a_slverr_access: assert property (@(posedge clk) disable iff (!reset_n)
        pslverr_o |-> (access && $past(psel_i && !penable_i)));

endmodule

// File: logic/valu_collect.sv
////////////////////////////////////////////////////////////////////////////
// Lane collector, done one edge after the lanes respond
// Reductions take one more edge for the cross-lane sum
// op and sew must stay stable until done
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_collect (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  valu_pkg::lane_rsp_t [valu_pkg::LANES-1:0] lane_rsp_i,
    input  valu_pkg::valu_op_e                        op_i,
    input  valu_pkg::sew_e                            sew_i,
    input  logic [31:0]                               opb0_i,
    output logic [valu_pkg::VLEN-1:0]                 result_o,
    output logic [15:0]                               mask_o,
    output logic                                      done_o
);
    import valu_pkg::*;

    logic [LANES-1:0]  valids;
    logic [VLEN-1:0]   words;
    logic [15:0]       mask_d;
    logic [LLEN-1:0]   wmask;
    logic [LLEN-1:0]   red_sum;
    logic [LLEN-1:0]   red_q;
    logic              red_pend_q;
    logic              rsp_v;
    logic              is_red;

    assign rsp_v  = lane_rsp_i[0].valid;
    assign is_red = (op_i == REDSUM);

    always_comb begin
        case (sew_i)
            EW8:     wmask = 32'h0000_00ff;
            EW16:    wmask = 32'h0000_ffff;
            default: wmask = 32'hffff_ffff;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Gather words, mask bits and partial sums
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mask_d  = '0;
        red_sum = opb0_i & wmask;
        for (int l = 0; l < LANES; l++) begin
            valids[l]               = lane_rsp_i[l].valid;
            words[l*LLEN +: LLEN]   = lane_rsp_i[l].result.w;
            red_sum                 = red_sum + lane_rsp_i[l].result.w;
            // Element index is lane times elements per lane plus flag index
            case (sew_i)
                EW8:     mask_d[l*LBYTES +: LBYTES] = lane_rsp_i[l].flags;
                EW16:    mask_d[l*2 +: 2]           = lane_rsp_i[l].flags[1:0];
                default: mask_d[l]                  = lane_rsp_i[l].flags[0];
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            red_pend_q <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            red_pend_q <= rsp_v && is_red;
            done_o     <= (rsp_v && !is_red) || red_pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_v && is_red) begin
            red_q <= red_sum;
        end else if (rsp_v) begin
            result_o <= words;
            mask_o   <= mask_d;
        end
        // Second reduction stage truncates to the element width
        if (red_pend_q) begin
            result_o <= VLEN'(red_q & wmask);
            mask_o   <= '0;
        end
    end

    // All four lanes run in lockstep
    a_lanes_lockstep: assert property (@(posedge clk) disable iff (!reset_n)
        (valids == '0) || (&valids));

endmodule

// File: logic/valu_dispatch.sv
////////////////////////////////////////////////////////////////////////////
// Command dispatcher, one lane command per start pulse
// Lane commands hold until the next start, the collector reads op and sew
// from lane 0 for the whole operation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_dispatch (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      start_i,
    input  valu_pkg::valu_op_e                        op_i,
    input  valu_pkg::sew_e                            sew_i,
    input  logic [4:0]                                vl_i,
    input  logic [valu_pkg::VLEN-1:0]                 opa_i,
    input  logic [valu_pkg::VLEN-1:0]                 opb_i,
    input  logic                                      done_i,
    output logic                                      busy_o,
    output valu_pkg::lane_cmd_t [valu_pkg::LANES-1:0] lane_cmd_o
);
    import valu_pkg::*;

    logic [1:0]                shift;
    logic [4:0]                n_elem;
    logic [4:0]                vl_eff;
    logic [LANES*LBYTES-1:0]   byte_en;
    lane_cmd_t [LANES-1:0]     cmd_d;
    lane_cmd_t [LANES-1:0]     cmd_q;
    logic                      valid_q;
    logic                      busy_q;

    always_comb begin
        case (sew_i)
            EW8:     shift = 2'd0;
            EW16:    shift = 2'd1;
            default: shift = 2'd2;
        endcase
        n_elem = 5'd16 >> shift;
        vl_eff = (vl_i > n_elem) ? n_elem : vl_i;

        // Byte slot p belongs to element p >> shift
        for (int p = 0; p < LANES*LBYTES; p++) begin
            byte_en[p] = ((5'(p) >> shift) < vl_eff);
        end

        for (int l = 0; l < LANES; l++) begin
            cmd_d[l].valid   = 1'b1;
            cmd_d[l].op      = op_i;
            cmd_d[l].sew     = sew_i;
            cmd_d[l].a.w     = opa_i[l*LLEN +: LLEN];
            cmd_d[l].b.w     = opb_i[l*LLEN +: LLEN];
            cmd_d[l].elem_en = byte_en[l*LBYTES +: LBYTES];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            valid_q <= start_i;
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            cmd_q <= cmd_d;
        end
    end

    // Valid is a one-cycle pulse over the held command
    always_comb begin
        lane_cmd_o = cmd_q;
        for (int l = 0; l < LANES; l++) begin
            lane_cmd_o[l].valid = valid_q;
        end
    end

    assign busy_o = busy_q;

    // Register block must refuse a new command while one is running
    a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
        start_i |-> !busy_q);

endmodule

// File: logic/valu_lane.sv
////////////////////////////////////////////////////////////////////////////
// One 32-bit lane, all element widths, one cycle latency
// Unknown op codes give a zero word and clear flags
// Width code 3 is handled as 32-bit elements
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_lane (
    input  logic                 clk,
    input  logic                 reset_n,
    input  valu_pkg::lane_cmd_t  cmd_i,
    output valu_pkg::lane_rsp_t  rsp_o
);
    import valu_pkg::*;

    lane_word_u         res_d;
    lane_word_u         psum;
    lane_word_u         res_q;
    logic [LBYTES-1:0]  flags_d;
    logic [LBYTES-1:0]  flags_q;
    logic               valid_q;

    // Operands arrive MSB aligned, so wrap and ordering hold at any width.
    // Returns the compare flag above the result word
    function automatic logic [LLEN:0] elem_op(valu_op_e op, logic [LLEN-1:0] a,
                                              logic [LLEN-1:0] b);
        logic lt_s;
        logic lt_u;
        lt_s = ($signed(a) < $signed(b));
        lt_u = (a < b);
        case (op)
            ADD:     return {1'b0, a + b};
            SUB:     return {1'b0, a - b};
            AND:     return {1'b0, a & b};
            OR:      return {1'b0, a | b};
            XOR:     return {1'b0, a ^ b};
            MIN:     return {1'b0, lt_s ? a : b};
            MAX:     return {1'b0, lt_s ? b : a};
            MINU:    return {1'b0, lt_u ? a : b};
            MAXU:    return {1'b0, lt_u ? b : a};
            MSEQ:    return {a == b, {LLEN{1'b0}}};
            MSLT:    return {lt_s, {LLEN{1'b0}}};
            MSLTU:   return {lt_u, {LLEN{1'b0}}};
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Element datapath
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin : calc
        logic [LLEN:0] r;
        r       = '0;
        res_d.w = '0;
        psum.w  = '0;
        flags_d = '0;
        case (cmd_i.sew)
            EW8: begin
                for (int s = 0; s < LBYTES; s++) begin
                    r = elem_op(cmd_i.op, {cmd_i.a.b[s], 24'h0}, {cmd_i.b.b[s], 24'h0});
                    if (cmd_i.elem_en[s]) begin
                        res_d.b[s]  = r[31:24];
                        flags_d[s]  = r[LLEN];
                        psum.b[0]   = psum.b[0] + cmd_i.a.b[s];
                    end
                end
            end
            EW16: begin
                // Lowest byte slot of each half carries its enable
                for (int h = 0; h < 2; h++) begin
                    r = elem_op(cmd_i.op, {cmd_i.a.h[h], 16'h0}, {cmd_i.b.h[h], 16'h0});
                    if (cmd_i.elem_en[2*h]) begin
                        res_d.h[h]  = r[31:16];
                        flags_d[h]  = r[LLEN];
                        psum.h[0]   = psum.h[0] + cmd_i.a.h[h];
                    end
                end
            end
            default: begin
                r = elem_op(cmd_i.op, cmd_i.a.w, cmd_i.b.w);
                if (cmd_i.elem_en[0]) begin
                    res_d.w    = r[LLEN-1:0];
                    flags_d[0] = r[LLEN];
                    psum.w     = cmd_i.a.w;
                end
            end
        endcase

        // Partial sum sits in element 0, upper part stays zero
        if (cmd_i.op == REDSUM) begin
            res_d = psum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmd_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i.valid) begin
            res_q   <= res_d;
            flags_q <= flags_d;
        end
    end

    assign rsp_o = '{valid: valid_q, result: res_q, flags: flags_q};

endmodule

// File: logic/valu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared geometry, encodings and lane transport types of the vector ALU
// Lane count and lane width are fixed by the register map, so the
// register offsets below assume four 32-bit lanes and a 16-bit mask
////////////////////////////////////////////////////////////////////////////

package valu_pkg;

    // Vector geometry
    localparam int VLEN   = 128;
    localparam int LLEN   = 32;
    localparam int LANES  = 4;
    localparam int LBYTES = LLEN / 8;
    localparam int APB_AW = 8;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        MIN, MAX, MINU, MAXU,
        MSEQ, MSLT, MSLTU,
        REDSUM
    } valu_op_e;

    typedef enum logic [1:0] {
        EW8,
        EW16,
        EW32
    } sew_e;

    // One lane word, read per element width
    typedef union packed {
        logic [LBYTES-1:0][7:0]  b;
        logic [1:0][15:0]        h;
        logic [LLEN-1:0]         w;
    } lane_word_u;

    // elem_en has one bit per byte slot
    typedef struct packed {
        logic               valid;
        valu_op_e           op;
        sew_e               sew;
        lane_word_u         a;
        lane_word_u         b;
        logic [LBYTES-1:0]  elem_en;
    } lane_cmd_t;

    // flags are indexed by element number inside the lane
    typedef struct packed {
        logic               valid;
        lane_word_u         result;
        logic [LBYTES-1:0]  flags;
    } lane_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [APB_AW-1:0] REG_CMD    = 8'h00;
    localparam logic [APB_AW-1:0] REG_VL     = 8'h04;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;
    localparam logic [APB_AW-1:0] REG_OPA    = 8'h10;
    localparam logic [APB_AW-1:0] REG_OPB    = 8'h20;
    localparam logic [APB_AW-1:0] REG_RES    = 8'h30;
    localparam logic [APB_AW-1:0] REG_MASK   = 8'h40;

endpackage

// File: logic/valu_top.sv
////////////////////////////////////////////////////////////////////////////
// Vector ALU top, APB slave with four 32-bit lanes
// Host polls STATUS for done, no interrupt output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module valu_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [valu_pkg::APB_AW-1:0] paddr_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);
    import valu_pkg::*;

    logic                   start;
    logic                   busy;
    logic                   done;
    valu_op_e               op;
    sew_e                   sew;
    logic [4:0]             vl;
    logic [VLEN-1:0]        opa;
    logic [VLEN-1:0]        opb;
    logic [VLEN-1:0]        result;
    logic [15:0]            mask;
    lane_cmd_t [LANES-1:0]  lane_cmd;
    lane_rsp_t [LANES-1:0]  lane_rsp;

    valu_apb_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .busy_i    (busy),
        .done_i    (done),
        .result_i  (result),
        .mask_i    (mask),
        .start_o   (start),
        .op_o      (op),
        .sew_o     (sew),
        .vl_o      (vl),
        .opa_o     (opa),
        .opb_o     (opb)
    );

    valu_dispatch u_dispatch (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start),
        .op_i       (op),
        .sew_i      (sew),
        .vl_i       (vl),
        .opa_i      (opa),
        .opb_i      (opb),
        .done_i     (done),
        .busy_o     (busy),
        .lane_cmd_o (lane_cmd)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        valu_lane u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .cmd_i   (lane_cmd[l]),
            .rsp_o   (lane_rsp[l])
        );
    end

    // Every lane carries the same op and sew
    valu_collect u_collect (
        .clk        (clk),
        .reset_n    (reset_n),
        .lane_rsp_i (lane_rsp),
        .op_i       (lane_cmd[0].op),
        .sew_i      (lane_cmd[0].sew),
        .opb0_i     (lane_cmd[0].b.w),
        .result_o   (result),
        .mask_o     (mask),
        .done_o     (done)
    );

endmodule

// File: sim.f
+incdir+bench
logic/valu_pkg.sv
logic/valu_apb_regs.sv
logic/valu_dispatch.sv
logic/valu_lane.sv
logic/valu_collect.sv
logic/valu_top.sv
bench/valu_tb.sv
